// ==== logic/egress_pkg.sv ====
////////////////////////////////////////
// Egress sizes, vector types, descriptor
// structs and per-port scheduler state
////////////////////////////////////////
package egress_pkg;

    ////////////////////////////////////////
    // Build sizes
    localparam int NUM_EGR_PORTS   = 4;
    // Highest index is the highest priority
    localparam int QUEUES_PER_PORT = 4;
    localparam int NUM_QUEUES      = NUM_EGR_PORTS * QUEUES_PER_PORT;
    localparam int QUEUE_DEPTH     = 4;
    localparam int MAX_SEGS        = 8;
    localparam int DQ_LATENCY      = 1;
    localparam int PORT_CREDITS    = 4;

    // Field widths
    localparam int PORT_W   = $clog2(NUM_EGR_PORTS);
    localparam int PRIO_W   = $clog2(QUEUES_PER_PORT);
    localparam int QID_W    = PORT_W + PRIO_W;
    localparam int SEG_W    = 4;
    localparam int CREDIT_W = 3;
    localparam int QPTR_W   = $clog2(QUEUE_DEPTH);

    ////////////////////////////////////////
    // Vector types
    typedef logic [PORT_W-1:0]        port_id_t;
    typedef logic [PRIO_W-1:0]        prio_t;
    typedef logic [QID_W-1:0]         queue_id_t;
    typedef logic [SEG_W-1:0]         seg_count_t;
    typedef logic [CREDIT_W-1:0]      credit_t;
    typedef logic [NUM_QUEUES-1:0]    queue_mask_t;
    typedef logic [NUM_EGR_PORTS-1:0] port_mask_t;
    typedef logic [QPTR_W-1:0]        qptr_t;
    typedef logic [QPTR_W:0]          qcount_t;

    ////////////////////////////////////////
    // Descriptor and segment records
    typedef struct packed {
        logic       valid;
        queue_id_t  queue_id;
        seg_count_t seg_count;
    } enq_t;

    typedef struct packed {
        logic      valid;
        queue_id_t queue_id;
    } dq_req_t;

    typedef struct packed {
        logic       valid;
        logic       last;
        queue_id_t  queue_id;
        seg_count_t seg_idx;
    } dq_note_t;

    typedef enum logic {
        idle,
        in_packet
    } sched_state_e;

    // Queue id is port in the upper bits, priority below
    function automatic port_id_t qid_port(queue_id_t qid);
        return qid[QID_W-1:PRIO_W];
    endfunction

    function automatic queue_id_t qid_make(port_id_t port, prio_t prio);
        return {port, prio};
    endfunction

endpackage

// ==== logic/queue_store.sv ====
////////////////////////////////////////
// Per-queue descriptor FIFOs and the
// segment streamer for dequeue requests
////////////////////////////////////////
`timescale 1ns/1ps

module queue_store (
    input  logic                    dequeue_notification,
    input  logic                    reset,
    input  egress_pkg::enq_t        enq,
    input  egress_pkg::dq_req_t     dq_req,
    output egress_pkg::queue_mask_t queue_empty,
    output egress_pkg::queue_mask_t queue_full,
    output logic                    enq_drop,
    output egress_pkg::dq_note_t    dq_note
);

    egress_pkg::seg_count_t fifo_mem [egress_pkg::NUM_QUEUES][egress_pkg::QUEUE_DEPTH];
    egress_pkg::qptr_t      wr_ptr   [egress_pkg::NUM_QUEUES];
    egress_pkg::qptr_t      rd_ptr   [egress_pkg::NUM_QUEUES];
    egress_pkg::qcount_t    fill     [egress_pkg::NUM_QUEUES];
    egress_pkg::seg_count_t seg_idx  [egress_pkg::NUM_QUEUES];

    logic                    push;
    logic                    head_last;
    egress_pkg::seg_count_t  head_segs;
    egress_pkg::queue_mask_t push_mask;
    egress_pkg::queue_mask_t pop_mask;

    ////////////////////////////////////////
    // Occupancy flags
    always_comb begin
        for (int q = 0; q < egress_pkg::NUM_QUEUES; q++) begin
            queue_empty[q] = (fill[q] == '0);
            queue_full[q]  = (fill[q] == egress_pkg::qcount_t'(egress_pkg::QUEUE_DEPTH));
        end
    end

    // Full queue drops the descriptor
    assign push = enq.valid && !queue_full[enq.queue_id];

    // Head descriptor of the requested queue
    assign head_segs = fifo_mem[dq_req.queue_id][rd_ptr[dq_req.queue_id]];
    assign head_last = (seg_idx[dq_req.queue_id] == egress_pkg::seg_count_t'(head_segs - 1'b1));

    assign push_mask = push ? (egress_pkg::queue_mask_t'(1) << enq.queue_id) : '0;
    assign pop_mask  = (dq_req.valid && head_last) ?
                       (egress_pkg::queue_mask_t'(1) << dq_req.queue_id) : '0;

    always_ff @(posedge dequeue_notification) begin
        if (push) begin
            fifo_mem[enq.queue_id][wr_ptr[enq.queue_id]] <= enq.seg_count;
        end
    end

    ////////////////////////////////////////
    // Pointers, fill counts, segment index
    always_ff @(posedge dequeue_notification) begin
        if (reset) begin
            for (int q = 0; q < egress_pkg::NUM_QUEUES; q++) begin
                wr_ptr[q]  <= '0;
                rd_ptr[q]  <= '0;
                fill[q]    <= '0;
                seg_idx[q] <= '0;
            end
            enq_drop <= 1'b0;
            dq_note  <= '0;
        end else begin
            enq_drop <= enq.valid && queue_full[enq.queue_id];
            for (int q = 0; q < egress_pkg::NUM_QUEUES; q++) begin
                if (push_mask[q]) begin
                    wr_ptr[q] <= wr_ptr[q] + 1'b1;
                end
                if (pop_mask[q]) begin
                    rd_ptr[q] <= rd_ptr[q] + 1'b1;
                end
                fill[q] <= egress_pkg::qcount_t'(fill[q] + push_mask[q] - pop_mask[q]);
            end

            // One segment per request, last one pops the head
            if (dq_req.valid) begin
                seg_idx[dq_req.queue_id] <= head_last ? '0 :
                    egress_pkg::seg_count_t'(seg_idx[dq_req.queue_id] + 1'b1);
                dq_note.valid    <= 1'b1;
                dq_note.last     <= head_last;
                dq_note.queue_id <= dq_req.queue_id;
                dq_note.seg_idx  <= seg_idx[dq_req.queue_id];
            end else begin
                dq_note.valid <= 1'b0;
            end
        end
    end

    // Scheduler only picks queues it saw non-empty
    a_req_not_empty: assert property (@(posedge dequeue_notification) disable iff (reset)
        dq_req.valid |-> !queue_empty[dq_req.queue_id]);

    a_enq_size: assert property (@(posedge dequeue_notification) disable iff (reset)
        enq.valid |-> (enq.seg_count != '0) && (enq.seg_count <= egress_pkg::MAX_SEGS));

endmodule

// ==== logic/egress_scheduler.sv ====
////////////////////////////////////////
// Port round robin with busy window and
// sticky strict-priority queue pick
////////////////////////////////////////
`timescale 1ns/1ps

module egress_scheduler (
    input  logic                    dequeue_notification,
    input  logic                    reset,
    input  egress_pkg::queue_mask_t queue_empty,
    input  egress_pkg::port_mask_t  egr_buf_ready,
    input  egress_pkg::dq_note_t    dq_note,
    output egress_pkg::dq_req_t     dq_req
);

    egress_pkg::port_mask_t port_has_work;
    egress_pkg::port_mask_t port_busy;
    logic [egress_pkg::DQ_LATENCY:0] busy_sr [egress_pkg::NUM_EGR_PORTS];

    logic                 pick_valid;
    egress_pkg::port_id_t pick_port;
    logic                 grant_valid;
    egress_pkg::port_id_t grant_port;

    egress_pkg::sched_state_e pkt_state   [egress_pkg::NUM_EGR_PORTS];
    egress_pkg::prio_t        active_prio [egress_pkg::NUM_EGR_PORTS];
    egress_pkg::prio_t        sel_prio;
    logic [egress_pkg::QUEUES_PER_PORT-1:0] grant_empty;

    ////////////////////////////////////////
    // Port eligibility
    always_comb begin
        for (int p = 0; p < egress_pkg::NUM_EGR_PORTS; p++) begin
            port_has_work[p] = ~&queue_empty[p*egress_pkg::QUEUES_PER_PORT +:
                                             egress_pkg::QUEUES_PER_PORT];
            port_busy[p]     = |busy_sr[p];
        end
    end

    // Search starts one past the last granted port
    always_comb begin
        egress_pkg::port_id_t cand;
        pick_valid = 1'b0;
        pick_port  = grant_port;
        cand       = grant_port;
        for (int off = 1; off <= egress_pkg::NUM_EGR_PORTS; off++) begin
            cand = egress_pkg::port_id_t'((int'(grant_port) + off) % egress_pkg::NUM_EGR_PORTS);
            if (!pick_valid && port_has_work[cand] && !port_busy[cand] && egr_buf_ready[cand]) begin
                pick_valid = 1'b1;
                pick_port  = cand;
            end
        end
    end

    ////////////////////////////////////////
    // Grant stage
    always_ff @(posedge dequeue_notification) begin
        if (reset) begin
            grant_valid <= 1'b0;
            // Port 0 goes first out of reset
            grant_port  <= egress_pkg::port_id_t'(egress_pkg::NUM_EGR_PORTS - 1);
            for (int p = 0; p < egress_pkg::NUM_EGR_PORTS; p++) begin
                busy_sr[p] <= '0;
            end
        end else begin
            grant_valid <= pick_valid;
            if (pick_valid) begin
                grant_port <= pick_port;
            end
            // Busy until its segment note is out
            for (int p = 0; p < egress_pkg::NUM_EGR_PORTS; p++) begin
                busy_sr[p] <= {busy_sr[p][egress_pkg::DQ_LATENCY-1:0],
                               pick_valid && (pick_port == egress_pkg::port_id_t'(p))};
            end
        end
    end

    ////////////////////////////////////////
    // Queue pick for the granted port
    assign grant_empty = queue_empty[grant_port*egress_pkg::QUEUES_PER_PORT +:
                                     egress_pkg::QUEUES_PER_PORT];

    // Mid-packet keeps the active queue, else highest non-empty wins
    always_comb begin
        sel_prio = active_prio[grant_port];
        if (pkt_state[grant_port] == egress_pkg::idle) begin
            for (int q = 0; q < egress_pkg::QUEUES_PER_PORT; q++) begin
                if (!grant_empty[q]) begin
                    sel_prio = egress_pkg::prio_t'(q);
                end
            end
        end
    end

    always_ff @(posedge dequeue_notification) begin
        if (reset) begin
            dq_req <= '0;
            for (int p = 0; p < egress_pkg::NUM_EGR_PORTS; p++) begin
                pkt_state[p] <= egress_pkg::idle;
            end
        end else begin
            dq_req.valid    <= grant_valid;
            dq_req.queue_id <= egress_pkg::qid_make(grant_port, sel_prio);

            // Last segment frees the port for a new packet
            if (dq_note.valid && dq_note.last) begin
                pkt_state[egress_pkg::qid_port(dq_note.queue_id)] <= egress_pkg::idle;
            end
            if (grant_valid && (pkt_state[grant_port] == egress_pkg::idle)) begin
                pkt_state[grant_port] <= egress_pkg::in_packet;
            end
        end
    end

    always_ff @(posedge dequeue_notification) begin
        if (grant_valid && (pkt_state[grant_port] == egress_pkg::idle)) begin
            active_prio[grant_port] <= sel_prio;
        end
    end

    // Credit is still there when the request goes out
    a_req_port_ready: assert property (@(posedge dequeue_notification) disable iff (reset)
        dq_req.valid |-> |(egr_buf_ready &
                           (egress_pkg::port_mask_t'(1) << egress_pkg::qid_port(dq_req.queue_id))));

endmodule

// ==== logic/egress_credit_tracker.sv ====
////////////////////////////////////////
// Per-port egress buffer credit counters
////////////////////////////////////////
`timescale 1ns/1ps

module egress_credit_tracker (
    input  logic                   dequeue_notification,
    input  logic                   reset,
    input  egress_pkg::dq_req_t    dq_req,
    input  egress_pkg::port_mask_t credit_return,
    output egress_pkg::port_mask_t egr_buf_ready
);

    egress_pkg::credit_t    credit [egress_pkg::NUM_EGR_PORTS];
    egress_pkg::port_mask_t consume;

    // One credit per issued segment request
    always_comb begin
        consume = '0;
        if (dq_req.valid) begin
            consume[egress_pkg::qid_port(dq_req.queue_id)] = 1'b1;
        end
    end

    ////////////////////////////////////////
    // Counters
    always_ff @(posedge dequeue_notification) begin
        if (reset) begin
            for (int p = 0; p < egress_pkg::NUM_EGR_PORTS; p++) begin
                credit[p] <= egress_pkg::credit_t'(egress_pkg::PORT_CREDITS);
            end
        end else begin
            for (int p = 0; p < egress_pkg::NUM_EGR_PORTS; p++) begin
                credit[p] <= egress_pkg::credit_t'(credit[p] - consume[p] + credit_return[p]);
            end
        end
    end

    always_comb begin
        for (int p = 0; p < egress_pkg::NUM_EGR_PORTS; p++) begin
            egr_buf_ready[p] = (credit[p] != '0);
        end
    end

    for (genvar p = 0; p < egress_pkg::NUM_EGR_PORTS; p++) begin : g_chk
        // Requests only follow a grant taken with credit
        a_no_underflow: assert property (@(posedge dequeue_notification) disable iff (reset)
            consume[p] |-> (credit[p] != '0));

        a_no_overflow: assert property (@(posedge dequeue_notification) disable iff (reset)
            credit_return[p] |-> (int'(credit[p]) - int'(consume[p]) < egress_pkg::PORT_CREDITS));
    end

endmodule

// ==== logic/router_egress_top.sv ====
////////////////////////////////////////
// Egress traffic manager top level
////////////////////////////////////////
`timescale 1ns/1ps

module router_egress_top (
    input  logic                    dequeue_notification,
    input  logic                    reset,
    input  egress_pkg::enq_t        enq,
    input  egress_pkg::port_mask_t  credit_return,
    output egress_pkg::queue_mask_t queue_full,
    output logic                    enq_drop,
    output egress_pkg::dq_note_t    dq_note
);

    egress_pkg::queue_mask_t queue_empty;
    egress_pkg::port_mask_t  egr_buf_ready;
    egress_pkg::dq_req_t     dq_req;

    // Descriptor store and segment streamer
    queue_store u_queue_store (
        .dequeue_notification (dequeue_notification),
        .reset                (reset),
        .enq                  (enq),
        .dq_req               (dq_req),
        .queue_empty          (queue_empty),
        .queue_full           (queue_full),
        .enq_drop             (enq_drop),
        .dq_note              (dq_note)
    );

    egress_scheduler u_egress_scheduler (
        .dequeue_notification (dequeue_notification),
        .reset                (reset),
        .queue_empty          (queue_empty),
        .egr_buf_ready        (egr_buf_ready),
        .dq_note              (dq_note),
        .dq_req               (dq_req)
    );

    // Credit flow control toward the egress buffers
    egress_credit_tracker u_egress_credit_tracker (
        .dequeue_notification (dequeue_notification),
        .reset                (reset),
        .dq_req               (dq_req),
        .credit_return        (credit_return),
        .egr_buf_ready        (egr_buf_ready)
    );

endmodule

// ==== test/tb_router_egress.sv ====
////////////////////////////////////////
// Egress traffic manager testbench with
// stimulus table and reference model
////////////////////////////////////////
`timescale 1ns/1ps

module tb_router_egress;

    localparam int CLK_PERIOD  = 4;
    localparam int DRAIN_GAP   = 2;
    localparam int HOLD_PORT   = 1;
    localparam int NUM_ROWS    = 18;
    localparam int WATCHDOG_NS = NUM_ROWS * egress_pkg::MAX_SEGS * 3 * CLK_PERIOD + 2000;

    localparam logic [1:0] PH_FAIR = 2'd0;
    localparam logic [1:0] PH_BULK = 2'd1;
    localparam logic [1:0] PH_HOLD = 2'd2;
    localparam logic [1:0] PH_PRIO = 2'd3;

    typedef struct packed {
        egress_pkg::queue_id_t  qid;
        egress_pkg::seg_count_t segs;
        logic [1:0]             phase_id;
    } row_t;

    // Zero segments means a random size
    row_t stim [NUM_ROWS] = '{
        '{4'd3, 4'd8, PH_FAIR}, '{4'd6, 4'd8, PH_FAIR}, '{4'd9, 4'd8, PH_FAIR},
        '{4'd12, 4'd8, PH_FAIR},
        '{4'd0, 4'd0, PH_BULK}, '{4'd5, 4'd0, PH_BULK}, '{4'd10, 4'd0, PH_BULK},
        '{4'd15, 4'd8, PH_BULK}, '{4'd2, 4'd0, PH_BULK}, '{4'd2, 4'd0, PH_BULK},
        '{4'd2, 4'd0, PH_BULK}, '{4'd2, 4'd0, PH_BULK}, '{4'd2, 4'd0, PH_BULK},
        '{4'd13, 4'd0, PH_BULK},
        '{4'd5, 4'd4, PH_HOLD},
        // Port 1 at priorities 0, 3, 2
        '{4'd4, 4'd2, PH_PRIO}, '{4'd7, 4'd3, PH_PRIO}, '{4'd6, 4'd2, PH_PRIO}
    };
    int prio_order [3] = '{3, 2, 0};

    logic                    dequeue_notification = 1'b0;
    logic                    reset;
    egress_pkg::enq_t        enq;
    egress_pkg::port_mask_t  credit_return;
    egress_pkg::queue_mask_t queue_full;
    logic                    enq_drop;
    egress_pkg::dq_note_t    dq_note;

    // Reference model state
    int exp_q    [egress_pkg::NUM_QUEUES][$];
    int next_idx [egress_pkg::NUM_QUEUES] = '{default: 0};
    int active_q [egress_pkg::NUM_EGR_PORTS] = '{default: -1};
    int buf_fill [egress_pkg::NUM_EGR_PORTS] = '{default: 0};
    int lead     [egress_pkg::NUM_EGR_PORTS] = '{default: 0};
    bit hold     [egress_pkg::NUM_EGR_PORTS] = '{default: 1'b0};
    int start_order [$];
    int errors    = 0;
    int seg_seen  = 0;
    int enq_segs  = 0;
    int hold_sent = 0;
    int cycle     = 0;
    bit fair_on   = 1'b0;
    bit record_on = 1'b0;
    logic [31:0] lcg_state = 32'd57;

    router_egress_top dut (
        .dequeue_notification (dequeue_notification),
        .reset                (reset),
        .enq                  (enq),
        .credit_return        (credit_return),
        .queue_full           (queue_full),
        .enq_drop             (enq_drop),
        .dq_note              (dq_note)
    );

    always #(CLK_PERIOD / 2) dequeue_notification = ~dequeue_notification;

    // Sizes 1 to MAX_SEGS
    function automatic egress_pkg::seg_count_t random_segs();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return egress_pkg::seg_count_t'({1'b0, lcg_state[18:16]} + 4'd1);
    endfunction

    task automatic report_error(string msg);
        errors++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    // A port may lead the slowest one by at most two segments
    task automatic count_round(int p, bit pkt_end);
        bit all_served;
        all_served = 1'b1;
        lead[p]++;
        if (lead[p] >= 3) begin
            report_error($sformatf("port %0d got 3 segments before another port got one", p));
        end
        for (int i = 0; i < egress_pkg::NUM_EGR_PORTS; i++) begin
            if (lead[i] == 0) begin
                all_served = 1'b0;
            end
        end
        if (all_served) begin
            for (int i = 0; i < egress_pkg::NUM_EGR_PORTS; i++) begin
                lead[i]--;
            end
        end
        if (pkt_end) begin
            fair_on = 1'b0;
        end
    endtask

    ////////////////////////////////////////
    // Output monitor
    task automatic observe();
        int  q;
        int  p;
        bit  want_last;
        if (enq_drop) begin
            report_error("enq_drop set on a queue with room");
        end
        if (dq_note.valid) begin
            q = int'(dq_note.queue_id);
            p = q / egress_pkg::QUEUES_PER_PORT;
            seg_seen++;
            buf_fill[p]++;
            if (p == HOLD_PORT) begin
                hold_sent++;
            end
            if (buf_fill[p] > egress_pkg::PORT_CREDITS) begin
                report_error($sformatf("port %0d has %0d segments outstanding", p, buf_fill[p]));
            end
            if (exp_q[q].size() == 0) begin
                report_error($sformatf("segment from queue %0d with no packet pending", q));
            end else begin
                want_last = (next_idx[q] == exp_q[q][0] - 1);
                if (dq_note.seg_idx != egress_pkg::seg_count_t'(next_idx[q]) ||
                    dq_note.last != want_last) begin
                    report_error($sformatf("queue %0d idx %0d last %0b, expected idx %0d last %0b",
                        q, dq_note.seg_idx, dq_note.last, next_idx[q], want_last));
                end
                if (next_idx[q] == 0) begin
                    if (active_q[p] != -1) begin
                        report_error($sformatf("port %0d started queue %0d mid-packet", p, q));
                    end
                    active_q[p] = q;
                    if (record_on && p == HOLD_PORT) begin
                        start_order.push_back(q);
                    end
                end else if (active_q[p] != q) begin
                    report_error($sformatf("port %0d interleaved queue %0d", p, q));
                end
                if (fair_on) begin
                    count_round(p, want_last);
                end
                if (want_last) begin
                    void'(exp_q[q].pop_front());
                    next_idx[q] = 0;
                    active_q[p] = -1;
                end else begin
                    next_idx[q]++;
                end
            end
        end
        for (int i = 0; i < egress_pkg::NUM_QUEUES; i++) begin
            if (queue_full[i] != (exp_q[i].size() == egress_pkg::QUEUE_DEPTH)) begin
                report_error($sformatf("queue_full[%0d] is %0b", i, queue_full[i]));
            end
        end
    endtask

    // Model egress buffers free one slot per port every DRAIN_GAP cycles
    task automatic return_credits();
        if (cycle % DRAIN_GAP == 0) begin
            for (int p = 0; p < egress_pkg::NUM_EGR_PORTS; p++) begin
                if (!hold[p] && buf_fill[p] > 0) begin
                    credit_return[p] = 1'b1;
                    buf_fill[p]--;
                end
            end
        end
    endtask

    task automatic step();
        @(negedge dequeue_notification);
        cycle++;
        enq = '0;
        credit_return = '0;
        observe();
        return_credits();
    endtask

    task automatic drain_all();
        while (seg_seen != enq_segs || buf_fill.sum() != 0) step();
    endtask

    task automatic apply_row(row_t row);
        egress_pkg::seg_count_t segs;
        int q;
        q = int'(row.qid);
        segs = (row.segs != '0) ? row.segs : random_segs();
        step();
        while (exp_q[q].size() >= egress_pkg::QUEUE_DEPTH) step();
        enq.valid     = 1'b1;
        enq.queue_id  = row.qid;
        enq.seg_count = segs;
        exp_q[q].push_back(int'(segs));
        enq_segs += int'(segs);
    endtask

    ////////////////////////////////////////
    // Phase control
    task automatic begin_phase(logic [1:0] ph);
        if (ph == PH_FAIR) begin
            fair_on = 1'b1;
        end else if (ph == PH_HOLD) begin
            hold[HOLD_PORT] = 1'b1;
            hold_sent = 0;
        end else if (ph == PH_PRIO) begin
            start_order.delete();
            record_on = 1'b1;
        end
    endtask

    task automatic end_phase(logic [1:0] ph);
        if (ph == PH_HOLD) begin
            while (hold_sent < egress_pkg::PORT_CREDITS) step();
        end else if (ph == PH_PRIO) begin
            // Port 1 has work queued but no credit left
            repeat (12) step();
            if (hold_sent != egress_pkg::PORT_CREDITS) begin
                report_error($sformatf("held port sent %0d segments", hold_sent));
            end
            hold[HOLD_PORT] = 1'b0;
            drain_all();
            record_on = 1'b0;
            if (start_order.size() != 3) begin
                report_error($sformatf("%0d packets started on port 1", start_order.size()));
            end else begin
                for (int i = 0; i < 3; i++) begin
                    if (start_order[i] != HOLD_PORT * egress_pkg::QUEUES_PER_PORT +
                        prio_order[i]) begin
                        report_error($sformatf("start %0d was queue %0d", i, start_order[i]));
                    end
                end
            end
        end else begin
            drain_all();
            fair_on = 1'b0;
        end
    endtask

    initial begin
        reset = 1'b1;
        enq = '0;
        credit_return = '0;
        repeat (5) @(negedge dequeue_notification);
        reset = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (i == 0) begin
                begin_phase(stim[i].phase_id);
            end else if (stim[i].phase_id != stim[i - 1].phase_id) begin
                end_phase(stim[i - 1].phase_id);
                begin_phase(stim[i].phase_id);
            end
            apply_row(stim[i]);
        end
        end_phase(stim[NUM_ROWS - 1].phase_id);
        for (int q = 0; q < egress_pkg::NUM_QUEUES; q++) begin
            if (exp_q[q].size() != 0) begin
                report_error($sformatf("queue %0d still owes %0d packets", q, exp_q[q].size()));
            end
        end
        $display("Summary: %0d errors, %0d of %0d segments delivered",
            errors, seg_seen, enq_segs);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the table drained, %0d errors so far",
            WATCHDOG_NS, errors);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== sim.f ====
logic/egress_pkg.sv
logic/queue_store.sv
logic/egress_scheduler.sv
logic/egress_credit_tracker.sv
logic/router_egress_top.sv
test/tb_router_egress.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the router egress testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert \
    --top-module tb_router_egress \
    -f sim.f \
    -o sim_router_egress

status=0
./obj_dir/sim_router_egress > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
echo "Simulation finished without failures"
